// File: Bender.yml
package:
  name: armController

sources:
  - common/armCtrlPkg.sv
  - common/flagIf.sv
  - verilog/stageReg.sv
  - decode/controlDecoder.sv
  - execute/executeControl.sv
  - verilog/statusReg.sv
  - verilog/armController.sv
  - target: simulation
    files:
      - tb/tbClock.sv
      - tb/armControllerAsserts.sv
      - tb/armControllerTb.sv

// File: common/armCtrlPkg.sv
package armCtrlPkg;

  // ==========================================================
  // Widths
  // ==========================================================
  localparam int instrWidth   = 32;
  localparam int condWidth    = 4;
  localparam int flagWidth    = 4;  // NZCV
  localparam int aluCtrlWidth = 4;

  // ALU opcodes, same encoding as the data processing field
  localparam logic [aluCtrlWidth-1:0] aluAdd = 4'b0100;
  localparam logic [aluCtrlWidth-1:0] aluSub = 4'b0010;

  // Opcode classes in instr[27:26]
  localparam logic [1:0] opData   = 2'b00;
  localparam logic [1:0] opMem    = 2'b01;
  localparam logic [1:0] opBranch = 2'b10;

  // ==========================================================
  // Condition codes
  // ==========================================================
  localparam logic [condWidth-1:0] condEq = 4'h0;
  localparam logic [condWidth-1:0] condNe = 4'h1;
  localparam logic [condWidth-1:0] condCs = 4'h2;
  localparam logic [condWidth-1:0] condCc = 4'h3;
  localparam logic [condWidth-1:0] condMi = 4'h4;
  localparam logic [condWidth-1:0] condPl = 4'h5;
  localparam logic [condWidth-1:0] condVs = 4'h6;
  localparam logic [condWidth-1:0] condVc = 4'h7;
  localparam logic [condWidth-1:0] condHi = 4'h8;
  localparam logic [condWidth-1:0] condLs = 4'h9;
  localparam logic [condWidth-1:0] condGe = 4'hA;
  localparam logic [condWidth-1:0] condLt = 4'hB;
  localparam logic [condWidth-1:0] condGt = 4'hC;
  localparam logic [condWidth-1:0] condLe = 4'hD;
  localparam logic [condWidth-1:0] condAl = 4'hE;
  localparam logic [condWidth-1:0] condNv = 4'hF;

  // ==========================================================
  // Stage payloads
  // ==========================================================
  typedef struct packed {
    logic                    regWrite;
    logic                    memWrite;
    logic                    memtoReg;
    logic                    branch;
    logic                    pcSrc;       // Writes PC, branch or Rd == R15
    logic                    setFlags;
    logic                    aluSrc;      // Immediate operand B
    logic [aluCtrlWidth-1:0] aluControl;
    logic                    byteAccess;
    logic [condWidth-1:0]    cond;
  } ctrlE;

  typedef struct packed {
    logic       regWrite;
    logic       memWrite;
    logic       memtoReg;
    logic       pcSrc;
    logic [3:0] byteMask;  // One bit per byte lane
  } ctrlM;

  typedef struct packed {
    logic                 regWrite;
    logic                 memtoReg;
    logic                 pcSrc;
    logic                 setFlags;
    logic [flagWidth-1:0] flagsNext;
  } ctrlW;

endpackage

// File: common/flagIf.sv
`timescale 1ns/100ps

interface flagIf;
  import armCtrlPkg::*;

  // In-flight updates from M and W
  logic [flagWidth-1:0] flagsNextM;
  logic                 setFlagsM;
  logic [flagWidth-1:0] flagsNextW;
  logic                 setFlagsW;

  logic [flagWidth-1:0] flagsE;  // Forwarded flags seen by execute

  modport status (
    input  flagsNextM, setFlagsM, flagsNextW, setFlagsW,
    output flagsE
  );

  modport exec (input flagsE);

endinterface

// File: decode/controlDecoder.sv
`timescale 1ns/100ps

module controlDecoder (
  input  logic [armCtrlPkg::instrWidth-1:0] instrD,
  output logic [1:0]                        regSrcD,
  output logic [1:0]                        immSrcD,
  output armCtrlPkg::ctrlE                  ctrlD,
  output logic                              pcWrD
);
  import armCtrlPkg::*;

  logic [10:0]             controlsD;
  logic                    aluSrcD, memtoRegD, regWriteD, memWriteD, branchD;
  logic                    aluOpD;   // Data processing
  logic                    memOpD;   // LDR or STR
  logic                    validD;
  logic                    pcSrcD;
  logic [aluCtrlWidth-1:0] aluControlD;

  // ==========================================================
  // Main decoder
  // ==========================================================
  // {regSrc, immSrc, aluSrc, memtoReg, regWrite, memWrite, branch, aluOp, memOp}
  always_comb begin
    case (instrD[27:26])
      opData: begin
        if (instrD[25]) controlsD = 11'b00_00_1_0_1_0_0_1_0;  // Immediate operand
        else            controlsD = 11'b00_00_0_0_1_0_0_1_0;  // Register operand
      end
      opMem: begin
        if (instrD[25] && instrD[4]) begin
          controlsD = '0;  // Undefined encoding
        end else if (instrD[20]) begin
          // LDR, bit 25 low means 12-bit immediate offset
          if (!instrD[25]) controlsD = 11'b00_01_1_1_1_0_0_0_1;
          else             controlsD = 11'b00_01_0_1_1_0_0_0_1;
        end else begin
          // STR reads Rd as store data
          if (!instrD[25]) controlsD = 11'b10_01_1_0_0_1_0_0_1;
          else             controlsD = 11'b10_01_0_0_0_1_0_0_1;
        end
      end
      opBranch: controlsD = 11'b01_10_1_0_0_0_1_0_0;  // B, link ignored
      default:  controlsD = '0;                      // Class 11 not supported
    endcase
  end

  assign {regSrcD, immSrcD, aluSrcD, memtoRegD, regWriteD,
          memWriteD, branchD, aluOpD, memOpD} = controlsD;

  assign validD = aluOpD | memOpD | branchD;

  // ==========================================================
  // ALU decoder
  // ==========================================================
  always_comb begin
    if (aluOpD) begin
      aluControlD = instrD[24:21];
    end else if (memOpD) begin
      aluControlD = instrD[23] ? aluAdd : aluSub;  // Up/down bit
    end else if (branchD) begin
      aluControlD = aluAdd;                        // PC + offset
    end else begin
      aluControlD = '0;
    end
  end

  // Writing R15 redirects the PC
  assign pcSrcD = ((instrD[15:12] == 4'hF) & regWriteD) | branchD;
  assign pcWrD  = pcSrcD;

  always_comb begin
    ctrlD            = '0;
    ctrlD.regWrite   = regWriteD;
    ctrlD.memWrite   = memWriteD;
    ctrlD.memtoReg   = memtoRegD;
    ctrlD.branch     = branchD;
    ctrlD.pcSrc      = pcSrcD;
    ctrlD.setFlags   = aluOpD & instrD[20];  // S bit
    ctrlD.aluSrc     = aluSrcD;
    ctrlD.aluControl = aluControlD;
    ctrlD.byteAccess = memOpD & instrD[22];  // B bit
    ctrlD.cond       = validD ? instrD[instrWidth-1 -: condWidth] : '0;
  end

endmodule

// File: execute/executeControl.sv
`timescale 1ns/100ps

module executeControl (
  input  armCtrlPkg::ctrlE                 ctrlE,
  input  logic [armCtrlPkg::flagWidth-1:0] aluFlagsE,
  input  logic [1:0]                       addrLowE,
  flagIf.exec                              flags,
  output armCtrlPkg::ctrlM                 ctrlM,
  output logic [armCtrlPkg::flagWidth-1:0] flagsNextE,
  output logic                             setFlagsE,
  output logic                             branchTakenE
);
  import armCtrlPkg::*;

  logic       n, z, c, v;
  logic       condPass;
  logic [3:0] byteMaskE;

  assign {n, z, c, v} = flags.flagsE;

  // ==========================================================
  // Condition check
  // ==========================================================
  always_comb begin
    case (ctrlE.cond)
      condEq: condPass = z;
      condNe: condPass = !z;
      condCs: condPass = c;
      condCc: condPass = !c;
      condMi: condPass = n;
      condPl: condPass = !n;
      condVs: condPass = v;
      condVc: condPass = !v;
      condHi: condPass = c & !z;          // Unsigned higher
      condLs: condPass = !c | z;
      condGe: condPass = (n == v);        // Signed compares
      condLt: condPass = (n != v);
      condGt: condPass = !z & (n == v);
      condLe: condPass = z | (n != v);
      condAl: condPass = 1'b1;
      condNv: condPass = 1'b0;            // Never executes
    endcase
  end

  // Flags pass through unchanged unless the S bit survives the check
  assign setFlagsE    = ctrlE.setFlags & condPass;
  assign flagsNextE   = setFlagsE ? aluFlagsE : flags.flagsE;
  assign branchTakenE = ctrlE.branch & condPass;

  // Word store hits all lanes, byte store one lane
  assign byteMaskE = ctrlE.byteAccess ? (4'b0001 << addrLowE) : 4'b1111;

  always_comb begin
    ctrlM.regWrite = ctrlE.regWrite & condPass;
    ctrlM.memWrite = ctrlE.memWrite & condPass;
    ctrlM.memtoReg = ctrlE.memtoReg;
    ctrlM.pcSrc    = ctrlE.pcSrc & condPass;
    ctrlM.byteMask = byteMaskE;
  end

endmodule

// File: tb/armControllerAsserts.sv
`timescale 1ns/100ps

module armControllerAsserts (
  input logic             clk,
  input logic             rstN,
  input logic             flushE,
  input armCtrlPkg::ctrlE ctrlStageE,
  input logic             pcSrcW,
  input logic             pcWrPendingF,
  input logic             memWriteM,
  input logic [3:0]       byteMaskM
);

  int assertFails = 0;  // Failure count

  // A flushed E stage holds a bubble one cycle later
  flushEmptiesE: assert property (@(posedge clk) disable iff (!rstN)
    flushE |=> (ctrlStageE == '0))
    else begin
      assertFails++;
      $error("E stage payload not cleared after flushE");
    end

  // A PC write reaching W was pending in M one cycle before
  pcWrHoldsFetch: assert property (@(posedge clk) disable iff (!rstN)
    $rose(pcSrcW) |-> $past(pcWrPendingF))
    else begin
      assertFails++;
      $error("pcWrPendingF low in the cycle before a PC write reached W");
    end

  storeHasLanes: assert property (@(posedge clk) disable iff (!rstN)
    memWriteM |-> (byteMaskM != 4'b0000))
    else begin
      assertFails++;
      $error("Store in M with an empty byte mask");
    end

endmodule

bind armController armControllerAsserts asserts (
  .clk(clk), .rstN(rstN), .flushE(flushE), .ctrlStageE(ctrlStageE),
  .pcSrcW(pcSrcW), .pcWrPendingF(pcWrPendingF), .memWriteM(memWriteM),
  .byteMaskM(byteMaskM)
);

// File: tb/armControllerTb.sv
`timescale 1ns/100ps

module armControllerTb;
  import armCtrlPkg::*;

  logic        clk, rstN;
  logic [31:0] instrD;
  logic [3:0]  aluFlagsE;
  logic [1:0]  addrLowE;
  logic        stallE, flushE, stallM, stallW, flushW;
  logic [1:0]  regSrcD, immSrcD;
  logic        aluSrcE, memtoRegE, branchTakenE, memWriteM, regWriteM;
  logic [3:0]  aluControlE, byteMaskM, cpsrFlags;
  logic        regWriteW, memtoRegW, pcSrcW, pcWrPendingF;

  // Decoded fields of one instruction as the model sees them
  typedef struct packed {
    logic [1:0] regSrc, immSrc;
    logic       regWrite, memWrite, memtoReg, branch, pcSrc, setFlags, aluSrc, byteAcc;
    logic [3:0] aluCtl, cond;
  } decodeT;

  localparam logic [31:0] nopInstr = 32'hEC00_0000;  // Class 11 has no controls

  decodeT     mE;                                           // Model E stage
  logic       mRegWrite, mMemWrite, mMemtoReg, mPcSrc, mSetFlags;
  logic [3:0] mMask, mFlags;
  logic       wRegWrite, wMemtoReg, wPcSrc, wSetFlags;
  logic [3:0] wFlags, nzcv;                                 // Model NZCV copy
  integer     seed;
  int         checks, mismatches, timeouts, stallLen;
  logic       checkOn;

  tbClock clkGen (.clk);

  armController dut (.*);

  // ============================================================
  // Reference model
  // ============================================================
  function automatic decodeT predictCtrl(input logic [31:0] instr);
    decodeT r;
    r = '0;
    if (instr[27:26] == opData) begin
      r.regWrite = 1'b1;
      r.aluSrc   = instr[25];
      r.setFlags = instr[20];
      r.aluCtl   = instr[24:21];
    end else if (instr[27:26] == opMem && !(instr[25] && instr[4])) begin
      r.regSrc   = instr[20] ? 2'b00 : 2'b10;  // STR reads Rd
      r.immSrc   = 2'b01;
      r.aluSrc   = !instr[25];
      r.regWrite = instr[20];
      r.memtoReg = instr[20];
      r.memWrite = !instr[20];
      r.byteAcc  = instr[22];
      r.aluCtl   = instr[23] ? aluAdd : aluSub;
    end else if (instr[27:26] == opBranch) begin
      r.regSrc = 2'b01;
      r.immSrc = 2'b10;
      r.aluSrc = 1'b1;
      r.branch = 1'b1;
      r.aluCtl = aluAdd;
    end
    r.pcSrc = r.branch | (r.regWrite & (instr[15:12] == 4'hF));
    if (r.regWrite | r.memWrite | r.branch) r.cond = instr[31:28];
    return r;
  endfunction

  function automatic logic condOk(input logic [3:0] cond, input logic [3:0] f);
    logic n, z, c, v, base;
    {n, z, c, v} = f;
    case (cond[3:1])  // Odd codes negate the even ones
      3'd0: base = z;
      3'd1: base = c;
      3'd2: base = n;
      3'd3: base = v;
      3'd4: base = c & ~z;
      3'd5: base = (n == v);
      3'd6: base = ~z & (n == v);
      default: base = 1'b1;
    endcase
    if (cond == condNv) return 1'b0;
    return base ^ cond[0];
  endfunction

  function automatic logic [3:0] fwdFlags();
    if (mSetFlags) return mFlags;
    if (wSetFlags) return wFlags;
    return nzcv;
  endfunction

  always @(posedge clk) begin : model
    logic [3:0] fE;
    logic       pass;
    fE   = fwdFlags();
    pass = condOk(mE.cond, fE);
    if (!rstN) begin
      mE = '0;
      {mRegWrite, mMemWrite, mMemtoReg, mPcSrc, mSetFlags, mMask, mFlags} = '0;
      {wRegWrite, wMemtoReg, wPcSrc, wSetFlags, wFlags, nzcv} = '0;
    end else begin
      if (!stallW && wSetFlags) nzcv = wFlags;
      if (flushW) begin
        {wRegWrite, wMemtoReg, wPcSrc, wSetFlags, wFlags} = '0;
      end else if (!stallW) begin
        {wRegWrite, wMemtoReg, wPcSrc, wSetFlags, wFlags} =
          {mRegWrite, mMemtoReg, mPcSrc, mSetFlags, mFlags};
      end
      if (!stallM) begin
        mRegWrite = mE.regWrite & pass;
        mMemWrite = mE.memWrite & pass;
        mMemtoReg = mE.memtoReg;
        mPcSrc    = mE.pcSrc & pass;
        mSetFlags = mE.setFlags & pass;
        mFlags    = mSetFlags ? aluFlagsE : fE;
        mMask     = 4'b1111;
        if (mE.byteAcc) begin
          mMask           = 4'b0000;
          mMask[addrLowE] = 1'b1;  // Single lane
        end
      end
      if (flushE) mE = '0;
      else if (!stallE) mE = predictCtrl(instrD);
    end
  end

  // ============================================================
  // Comparing process
  // ============================================================
  task automatic checkVal(input string name, input logic [31:0] got, input logic [31:0] exp);
    checks++;
    if (got !== exp) begin
      mismatches++;
      $display("Error at %0t ns: %s is %0h, expected %0h", $time, name, got, exp);
    end
  endtask

  always @(negedge clk) begin : compare
    decodeT dec;
    dec = predictCtrl(instrD);
    if (checkOn) begin
      checkVal("regSrcD", regSrcD, dec.regSrc);
      checkVal("immSrcD", immSrcD, dec.immSrc);
      checkVal("aluSrcE", aluSrcE, mE.aluSrc);
      checkVal("aluControlE", aluControlE, mE.aluCtl);
      checkVal("memtoRegE", memtoRegE, mE.memtoReg);
      checkVal("branchTakenE", branchTakenE, mE.branch & condOk(mE.cond, fwdFlags()));
      checkVal("memWriteM", memWriteM, mMemWrite);
      checkVal("byteMaskM", byteMaskM, mMask);
      checkVal("regWriteM", regWriteM, mRegWrite);
      checkVal("regWriteW", regWriteW, wRegWrite);
      checkVal("memtoRegW", memtoRegW, wMemtoReg);
      checkVal("pcSrcW", pcSrcW, wPcSrc);
      checkVal("pcWrPendingF", pcWrPendingF, dec.pcSrc | mE.pcSrc | mPcSrc);
      checkVal("cpsrFlags", cpsrFlags, nzcv);
    end
  end

  // ============================================================
  // Stimulus
  // ============================================================
  task automatic step();
    @(posedge clk);
    #2;
  endtask

  task automatic issue(input logic [31:0] instr);
    instrD    = instr;
    aluFlagsE = $random(seed);
    addrLowE  = $random(seed);
    step();
  endtask

  function automatic logic [31:0] randInstr(input logic [1:0] cls, input logic alwaysCond);
    logic [31:0] r;
    r = $random(seed);
    r[27:26] = cls;
    if (alwaysCond) r[31:28] = condAl;
    return r;
  endfunction

  // Counts edges until the output rises and checks the latency
  task automatic waitLatency(input string name, input int expCycles);
    int   n;
    logic hit;
    n   = 0;
    hit = (name == "pcSrcW") ? pcSrcW : regWriteW;
    while (hit !== 1'b1 && n < 8) begin
      step();
      n++;
      hit = (name == "pcSrcW") ? pcSrcW : regWriteW;
    end
    if (hit !== 1'b1) begin
      timeouts++;
      $display("Timeout: %s did not rise within 8 cycles", name);
    end else if (n != expCycles) begin
      mismatches++;
      $display("Error at %0t ns: %s latency is %0d, expected %0d", $time, name, n, expCycles);
    end
  endtask

  initial begin
    seed      = 32'ha12759b1;
    rstN      = 1'b0;
    instrD    = nopInstr;
    aluFlagsE = '0;
    addrLowE  = '0;
    {stallE, flushE, stallM, stallW, flushW} = '0;
    {checks, mismatches, timeouts} = '0;
    checkOn   = 1'b0;
    step();
    checkOn = 1'b1;      // Payloads are defined after the first reset edge
    repeat (4) step();
    rstN = 1'b1;
    repeat (3) issue(nopInstr);

    repeat (20) issue(randInstr(opData, 1'b1));
    repeat (40) issue(randInstr(($random(seed) & 1) ? opData : opBranch, $random(seed) & 1));
    repeat (20) issue(randInstr(opMem, 1'b1) & ~32'h0200_0000);
    repeat (3) issue(nopInstr);

    // PC writes by data processing to R15 and by a branch
    issue(32'hE280_F004);
    instrD = nopInstr;
    waitLatency("pcSrcW", 2);
    issue(32'hEA00_0002);
    instrD = nopInstr;
    waitLatency("pcSrcW", 2);

    // Frozen pipeline followed by flushed ADD and STR
    repeat (4) begin
      issue(32'hE081_1002);
      stallLen = 1 + ($random(seed) & 3);
      {stallE, stallM, stallW} = 3'b111;
      instrD = nopInstr;
      repeat (stallLen) step();
      {stallE, stallM, stallW} = 3'b000;
      waitLatency("regWriteW", 2);
    end
    flushE = 1'b1;
    issue(32'hE081_1002);
    issue(32'hE580_1000);
    flushE = 1'b0;
    repeat (4) issue(nopInstr);

    // Random traffic under random hazards
    repeat (100) begin
      stallE = ($random(seed) & 7) == 0;
      flushE = ($random(seed) & 7) == 0;
      stallM = ($random(seed) & 15) == 0;
      stallW = ($random(seed) & 15) == 0;
      flushW = ($random(seed) & 15) == 0;
      issue($random(seed));
    end
    {stallE, flushE, stallM, stallW, flushW} = '0;
    repeat (4) issue(nopInstr);

    $display("Checks %0d, mismatches %0d, timeouts %0d, assertion failures %0d",
             checks, mismatches, timeouts, dut.asserts.assertFails);
    if (mismatches == 0 && timeouts == 0 && dut.asserts.assertFails == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule

// File: tb/tbClock.sv
`timescale 1ns/100ps

module tbClock (
  output logic clk
);

  initial clk = 1'b0;

  always #10 clk = ~clk;  // 20 ns period

endmodule

// File: verilog/armController.sv
`timescale 1ns/100ps

module armController (
  input  logic                              clk,
  input  logic                              rstN,
  input  logic [armCtrlPkg::instrWidth-1:0] instrD,
  input  logic [armCtrlPkg::flagWidth-1:0]  aluFlagsE,
  input  logic [1:0]                        addrLowE,
  // Hazard unit
  input  logic                              stallE,
  input  logic                              flushE,
  input  logic                              stallM,
  input  logic                              stallW,
  input  logic                              flushW,
  // Datapath controls
  output logic [1:0]                        regSrcD,
  output logic [1:0]                        immSrcD,
  output logic                              aluSrcE,
  output logic [armCtrlPkg::aluCtrlWidth-1:0] aluControlE,
  output logic                              memtoRegE,
  output logic                              branchTakenE,
  output logic                              memWriteM,
  output logic [3:0]                        byteMaskM,
  output logic                              regWriteM,
  output logic                              regWriteW,
  output logic                              memtoRegW,
  output logic                              pcSrcW,
  output logic                              pcWrPendingF,
  output logic [armCtrlPkg::flagWidth-1:0]  cpsrFlags
);
  import armCtrlPkg::*;

  ctrlE                 ctrlD, ctrlStageE;
  ctrlM                 ctrlNextM, ctrlStageM;
  ctrlW                 ctrlNextW, ctrlStageW;
  logic [flagWidth:0]   flagSideM;  // {setFlags, flagsNext} beside ctrlM
  logic [flagWidth-1:0] flagsNextE;
  logic                 setFlagsE;
  logic                 pcWrD;

  flagIf flagBus ();

  // ==========================================================
  // Decode and execute
  // ==========================================================
  controlDecoder decoder (.instrD, .regSrcD, .immSrcD, .ctrlD, .pcWrD);

  stageReg #(.payloadT(ctrlE), .clearable(1'b1)) regE (
    .clk, .rstN, .en(!stallE), .clr(flushE), .d(ctrlD), .q(ctrlStageE)
  );

  executeControl execCtrl (
    .ctrlE(ctrlStageE), .aluFlagsE, .addrLowE, .flags(flagBus.exec),
    .ctrlM(ctrlNextM), .flagsNextE, .setFlagsE, .branchTakenE
  );

  // ==========================================================
  // Memory and writeback
  // ==========================================================
  stageReg #(.payloadT(ctrlM), .clearable(1'b0)) regM (
    .clk, .rstN, .en(!stallM), .clr(1'b0), .d(ctrlNextM), .q(ctrlStageM)
  );

  stageReg #(.payloadT(logic [flagWidth:0]), .clearable(1'b0)) regFlagM (
    .clk, .rstN, .en(!stallM), .clr(1'b0), .d({setFlagsE, flagsNextE}), .q(flagSideM)
  );

  assign ctrlNextW = '{regWrite:  ctrlStageM.regWrite,
                       memtoReg:  ctrlStageM.memtoReg,
                       pcSrc:     ctrlStageM.pcSrc,
                       setFlags:  flagSideM[flagWidth],
                       flagsNext: flagSideM[flagWidth-1:0]};

  stageReg #(.payloadT(ctrlW), .clearable(1'b1)) regW (
    .clk, .rstN, .en(!stallW), .clr(flushW), .d(ctrlNextW), .q(ctrlStageW)
  );

  assign flagBus.flagsNextM = flagSideM[flagWidth-1:0];
  assign flagBus.setFlagsM  = flagSideM[flagWidth];
  assign flagBus.flagsNextW = ctrlStageW.flagsNext;
  assign flagBus.setFlagsW  = ctrlStageW.setFlags;

  statusReg status (.clk, .rstN, .en(!stallW), .flags(flagBus.status), .cpsrFlags);

  // Outputs
  assign aluSrcE      = ctrlStageE.aluSrc;
  assign aluControlE  = ctrlStageE.aluControl;
  assign memtoRegE    = ctrlStageE.memtoReg;
  assign memWriteM    = ctrlStageM.memWrite;
  assign byteMaskM    = ctrlStageM.byteMask;
  assign regWriteM    = ctrlStageM.regWrite;
  assign regWriteW    = ctrlStageW.regWrite;
  assign memtoRegW    = ctrlStageW.memtoReg;
  assign pcSrcW       = ctrlStageW.pcSrc;
  assign pcWrPendingF = pcWrD | ctrlStageE.pcSrc | ctrlStageM.pcSrc;  // Hold fetch

endmodule

// File: verilog/stageReg.sv
`timescale 1ns/100ps

module stageReg #(
  parameter type payloadT  = logic,
  parameter bit  clearable = 1'b0
) (
  input  logic    clk,
  input  logic    rstN,
  input  logic    en,
  input  logic    clr,   // Only honoured when clearable is set
  input  payloadT d,
  output payloadT q
);

  // Flush beats stall, a cleared payload is a bubble
  always_ff @(posedge clk) begin
    if (!rstN) begin
      q <= '0;
    end else if (clearable && clr) begin
      q <= '0;
    end else if (en) begin
      q <= d;
    end
  end

endmodule

// File: verilog/statusReg.sv
`timescale 1ns/100ps

module statusReg (
  input  logic                             clk,
  input  logic                             rstN,
  input  logic                             en,
  flagIf.status                            flags,
  output logic [armCtrlPkg::flagWidth-1:0] cpsrFlags
);
  import armCtrlPkg::*;

  logic [flagWidth-1:0] nzcv;  // Architectural flags

  always_ff @(posedge clk) begin
    if (!rstN) begin
      nzcv <= '0;
    end else if (en && flags.setFlagsW) begin
      nzcv <= flags.flagsNextW;
    end
  end

  // Youngest in-flight update wins
  always_comb begin
    if (flags.setFlagsM) begin
      flags.flagsE = flags.flagsNextM;
    end else if (flags.setFlagsW) begin
      flags.flagsE = flags.flagsNextW;
    end else begin
      flags.flagsE = nzcv;
    end
  end

  assign cpsrFlags = nzcv;

endmodule

// File: vlog.f
common/armCtrlPkg.sv
common/flagIf.sv
verilog/stageReg.sv
decode/controlDecoder.sv
execute/executeControl.sv
verilog/statusReg.sv
verilog/armController.sv
tb/tbClock.sv
tb/armControllerAsserts.sv
tb/armControllerTb.sv
